// File: include/decoder_settings.svh
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// opcode field, instr[6:2]
`define DEC_OPC_LOAD          5'b00000
`define DEC_OPC_MISC_MEM      5'b00011
`define DEC_OPC_OP_IMM        5'b00100
`define DEC_OPC_AUIPC         5'b00101
`define DEC_OPC_STORE         5'b01000
`define DEC_OPC_OP            5'b01100
`define DEC_OPC_LUI           5'b01101
`define DEC_OPC_BRANCH        5'b11000
`define DEC_OPC_JALR          5'b11001
`define DEC_OPC_JAL           5'b11011
`define DEC_OPC_SYSTEM        5'b11100

// ALU operation codes
`define DEC_ALU_ADD           5'b00000
`define DEC_ALU_SUB           5'b01000
`define DEC_ALU_XOR           5'b00100
`define DEC_ALU_OR            5'b00110
`define DEC_ALU_AND           5'b00111
`define DEC_ALU_SLL           5'b00001
`define DEC_ALU_SRL           5'b00101
`define DEC_ALU_SRA           5'b01101
`define DEC_ALU_SLTS          5'b00010
`define DEC_ALU_SLTU          5'b00011
`define DEC_ALU_EQ            5'b11000
`define DEC_ALU_NE            5'b11001
`define DEC_ALU_LTS           5'b11100
`define DEC_ALU_GES           5'b11101
`define DEC_ALU_LTU           5'b11110
`define DEC_ALU_GEU           5'b11111

// load/store sizes, same as funct3
`define DEC_LDST_B            3'b000
`define DEC_LDST_H            3'b001
`define DEC_LDST_W            3'b010
`define DEC_LDST_BU           3'b100
`define DEC_LDST_HU           3'b101

`define DEC_OP_A_RS1          2'b00
`define DEC_OP_A_CURR_PC      2'b01
`define DEC_OP_A_ZERO         2'b10

`define DEC_OP_B_RS2          3'b000
`define DEC_OP_B_IMM_I        3'b001
`define DEC_OP_B_IMM_U        3'b010
`define DEC_OP_B_IMM_S        3'b011
`define DEC_OP_B_INCR         3'b100

`define DEC_WB_EX_RESULT      1'b0
`define DEC_WB_LSU_DATA       1'b1

`define DEC_JUMP_NONE         2'b00
`define DEC_JUMP_RS1          2'b01
`define DEC_JUMP_MEPC         2'b10
`define DEC_JUMP_MTVEC        2'b11

`define DEC_CSR_OP_MRET_TRAP  3'b100   // bit 2 of csr op

`endif

// File: src/decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] instr_t;     // raw instruction word
    typedef logic [4:0]  opcode_t;    // instr[6:2]
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    typedef logic [4:0]  alu_op_t;
    typedef logic [1:0]  op_a_sel_t;
    typedef logic [2:0]  op_b_sel_t;
    typedef logic [2:0]  mem_size_t;  // equals funct3 of the access

    // none, rs1, mepc, mtvec
    typedef logic [1:0]  jump_sel_t;

    // bit 2 is mret or trap entry, bits 1..0 are write/set/clear
    typedef logic [2:0]  csr_op_t;

endpackage

// File: src/funct_decoder.sv
`timescale 1ns/1ps

`include "decoder_settings.svh"

module funct_decoder import decode_pkg::*; (
    input  instr_t    instr_i,
    output alu_op_t   alu_op_r_o,     // R-type
    output alu_op_t   alu_op_i_o,     // I-type arithmetic
    output alu_op_t   alu_op_br_o,    // branch compare
    output mem_size_t load_size_o,
    output mem_size_t store_size_o,
    output logic      r_legal_o,
    output logic      i_legal_o,
    output logic      br_legal_o,
    output logic      load_legal_o,
    output logic      store_legal_o
);

    funct3_t funct3;
    funct7_t funct7;
    logic    f7_zero;
    logic    f7_alt;                  // 0x20 selects SUB/SRA

    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign f7_zero = (funct7 == 7'h00);
    assign f7_alt  = (funct7 == 7'h20);

    always_comb begin
        alu_op_r_o  = `DEC_ALU_ADD;
        alu_op_i_o  = `DEC_ALU_ADD;
        alu_op_br_o = `DEC_ALU_EQ;
        br_legal_o  = 1'b1;
        case (funct3)
            3'h0: begin
                alu_op_r_o = f7_alt ? `DEC_ALU_SUB : `DEC_ALU_ADD;
            end
            3'h1: begin
                alu_op_r_o  = `DEC_ALU_SLL;
                alu_op_i_o  = `DEC_ALU_SLL;
                alu_op_br_o = `DEC_ALU_NE;
            end
            3'h2: begin
                alu_op_r_o = `DEC_ALU_SLTS;
                alu_op_i_o = `DEC_ALU_SLTS;
                br_legal_o = 1'b0;            // no branch here
            end
            3'h3: begin
                alu_op_r_o = `DEC_ALU_SLTU;
                alu_op_i_o = `DEC_ALU_SLTU;
                br_legal_o = 1'b0;
            end
            3'h4: begin
                alu_op_r_o  = `DEC_ALU_XOR;
                alu_op_i_o  = `DEC_ALU_XOR;
                alu_op_br_o = `DEC_ALU_LTS;
            end
            3'h5: begin
                alu_op_r_o  = f7_alt ? `DEC_ALU_SRA : `DEC_ALU_SRL;
                alu_op_i_o  = f7_alt ? `DEC_ALU_SRA : `DEC_ALU_SRL;
                alu_op_br_o = `DEC_ALU_GES;
            end
            3'h6: begin
                alu_op_r_o  = `DEC_ALU_OR;
                alu_op_i_o  = `DEC_ALU_OR;
                alu_op_br_o = `DEC_ALU_LTU;
            end
            default: begin
                alu_op_r_o  = `DEC_ALU_AND;
                alu_op_i_o  = `DEC_ALU_AND;
                alu_op_br_o = `DEC_ALU_GEU;
            end
        endcase
    end

    // alt funct7 only with ADD/SUB and SRL/SRA
    assign r_legal_o = f7_zero || (f7_alt && (funct3 == 3'h0 || funct3 == 3'h5));

    // only the shifts look at funct7
    assign i_legal_o = (funct3 == 3'h1) ? f7_zero :
                       (funct3 == 3'h5) ? (f7_zero || f7_alt) : 1'b1;

    assign load_legal_o  = (funct3 != 3'h3) && (funct3 != 3'h6) && (funct3 != 3'h7);
    assign store_legal_o = (funct3 <= 3'h2);

    // unused load encodings fall back to zero
    assign load_size_o  = load_legal_o ? funct3 : `DEC_LDST_B;
    assign store_size_o = funct3;

endmodule

// File: src/main_decoder.sv
`timescale 1ns/1ps

`include "decoder_settings.svh"

module main_decoder import decode_pkg::*; (
    input  instr_t    instr_i,
    input  logic      irq_i,            // pending interrupt
    input  alu_op_t   alu_op_r_i,
    input  alu_op_t   alu_op_i_i,
    input  alu_op_t   alu_op_br_i,
    input  mem_size_t load_size_i,
    input  mem_size_t store_size_i,
    input  logic      r_legal_i,
    input  logic      i_legal_i,
    input  logic      br_legal_i,
    input  logic      load_legal_i,
    input  logic      store_legal_i,
    output alu_op_t   alu_op_o,
    output op_a_sel_t op_a_sel_o,
    output op_b_sel_t op_b_sel_o,
    output logic      mem_req_o,
    output logic      mem_we_o,         // 1 is store
    output mem_size_t mem_size_o,
    output logic      gpr_we_o,
    output logic      wb_src_sel_o,
    output logic      branch_o,
    output logic      jal_o,
    output jump_sel_t jump_sel_o,
    output csr_op_t   csr_op_o,
    output logic      csr_o,
    output logic      illegal_instr_o
);

    opcode_t opcode;
    funct3_t funct3;
    logic    illegal;

    assign opcode = instr_i[6:2];
    assign funct3 = instr_i[14:12];

    always_comb begin
        case (opcode)
            `DEC_OPC_OP:       illegal = !r_legal_i;
            `DEC_OPC_OP_IMM:   illegal = !i_legal_i;
            `DEC_OPC_BRANCH:   illegal = !br_legal_i;
            `DEC_OPC_LOAD:     illegal = !load_legal_i;
            `DEC_OPC_STORE:    illegal = !store_legal_i;
            `DEC_OPC_JALR:     illegal = (funct3 != 3'h0);
            `DEC_OPC_SYSTEM:   illegal = (funct3 > 3'h3);
            `DEC_OPC_LUI,
            `DEC_OPC_AUIPC,
            `DEC_OPC_JAL,
            `DEC_OPC_MISC_MEM: illegal = 1'b0;
            default:           illegal = 1'b1;    // unknown opcode
        endcase
        if (instr_i[1:0] != 2'b11)
            illegal = 1'b1;                       // compressed or junk
    end

    // irq wins over an illegal instruction
    assign illegal_instr_o = illegal && !irq_i;

    always_comb begin
        // all zero is also the nop for illegal and fence
        alu_op_o     = `DEC_ALU_ADD;
        op_a_sel_o   = `DEC_OP_A_RS1;
        op_b_sel_o   = `DEC_OP_B_RS2;
        mem_req_o    = 1'b0;
        mem_we_o     = 1'b0;
        mem_size_o   = `DEC_LDST_B;
        gpr_we_o     = 1'b0;
        wb_src_sel_o = `DEC_WB_EX_RESULT;
        branch_o     = 1'b0;
        jal_o        = 1'b0;
        jump_sel_o   = `DEC_JUMP_NONE;
        csr_op_o     = 3'b000;
        csr_o        = 1'b0;

        if (irq_i) begin
            // trap entry, rd gets pc+4 and pc goes to mtvec
            gpr_we_o   = 1'b1;
            op_a_sel_o = `DEC_OP_A_CURR_PC;
            op_b_sel_o = `DEC_OP_B_INCR;
            jump_sel_o = `DEC_JUMP_MTVEC;
            csr_op_o   = `DEC_CSR_OP_MRET_TRAP;
        end else if (!illegal) begin
            case (opcode)
                `DEC_OPC_OP: begin
                    gpr_we_o = 1'b1;
                    alu_op_o = alu_op_r_i;
                end
                `DEC_OPC_OP_IMM: begin
                    gpr_we_o   = 1'b1;
                    alu_op_o   = alu_op_i_i;
                    op_b_sel_o = `DEC_OP_B_IMM_I;
                end
                `DEC_OPC_LUI: begin
                    gpr_we_o   = 1'b1;
                    op_a_sel_o = `DEC_OP_A_ZERO;  // 0 + imm_u
                    op_b_sel_o = `DEC_OP_B_IMM_U;
                end
                `DEC_OPC_AUIPC: begin
                    gpr_we_o   = 1'b1;
                    op_a_sel_o = `DEC_OP_A_CURR_PC;
                    op_b_sel_o = `DEC_OP_B_IMM_U;
                end
                `DEC_OPC_LOAD: begin
                    gpr_we_o     = 1'b1;
                    mem_req_o    = 1'b1;
                    mem_size_o   = load_size_i;
                    op_b_sel_o   = `DEC_OP_B_IMM_I;
                    wb_src_sel_o = `DEC_WB_LSU_DATA;
                end
                `DEC_OPC_STORE: begin
                    mem_req_o  = 1'b1;
                    mem_we_o   = 1'b1;
                    mem_size_o = store_size_i;
                    op_b_sel_o = `DEC_OP_B_IMM_S; // split immediate
                end
                `DEC_OPC_BRANCH: begin
                    branch_o = 1'b1;
                    alu_op_o = alu_op_br_i;
                end
                `DEC_OPC_JAL: begin
                    gpr_we_o   = 1'b1;
                    jal_o      = 1'b1;
                    op_a_sel_o = `DEC_OP_A_CURR_PC;
                    op_b_sel_o = `DEC_OP_B_INCR;
                end
                `DEC_OPC_JALR: begin
                    gpr_we_o   = 1'b1;
                    jump_sel_o = `DEC_JUMP_RS1;
                    op_a_sel_o = `DEC_OP_A_CURR_PC;
                    op_b_sel_o = `DEC_OP_B_INCR;
                end
                `DEC_OPC_SYSTEM: begin
                    gpr_we_o = 1'b1;
                    if (funct3 == 3'h0) begin
                        // mret, return through mepc
                        op_a_sel_o = `DEC_OP_A_CURR_PC;
                        op_b_sel_o = `DEC_OP_B_INCR;
                        jump_sel_o = `DEC_JUMP_MEPC;
                        csr_op_o   = `DEC_CSR_OP_MRET_TRAP;
                    end else begin
                        // csr access goes out like a load
                        csr_o        = 1'b1;
                        mem_req_o    = 1'b1;
                        mem_size_o   = load_size_i;
                        op_b_sel_o   = `DEC_OP_B_IMM_I;
                        wb_src_sel_o = `DEC_WB_LSU_DATA;
                        case (funct3[1:0])
                            2'h1:    csr_op_o = 3'b001;   // csrrw
                            2'h2:    csr_op_o = 3'b011;   // csrrs
                            default: csr_op_o = 3'b010;   // csrrc
                        endcase
                    end
                end
                default: begin
                    // misc-mem stays a nop
                end
            endcase
        end
    end

endmodule

// File: src/ctrl_output_reg.sv
`timescale 1ns/1ps

module ctrl_output_reg import decode_pkg::*; (
    input  logic      clk_i,
    input  logic      en_int_rst,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    output logic      out_valid_o,
    input  logic      out_ready_i,
    input  alu_op_t   alu_op_i,
    input  op_a_sel_t op_a_sel_i,
    input  op_b_sel_t op_b_sel_i,
    input  logic      mem_req_i,
    input  logic      mem_we_i,
    input  mem_size_t mem_size_i,
    input  logic      gpr_we_i,
    input  logic      wb_src_sel_i,
    input  logic      branch_i,
    input  logic      jal_i,
    input  jump_sel_t jump_sel_i,
    input  csr_op_t   csr_op_i,
    input  logic      csr_i,
    input  logic      illegal_instr_i,
    output alu_op_t   alu_op_o,
    output op_a_sel_t op_a_sel_o,
    output op_b_sel_t op_b_sel_o,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output mem_size_t mem_size_o,
    output logic      gpr_we_o,
    output logic      wb_src_sel_o,
    output logic      branch_o,
    output logic      jal_o,
    output jump_sel_t jump_sel_o,
    output csr_op_t   csr_op_o,
    output logic      csr_o,
    output logic      illegal_instr_o
);

    logic load;

    // free slot, or the held word leaves this edge
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i) begin
        if (en_int_rst) begin
            out_valid_o     <= 1'b0;
            alu_op_o        <= '0;
            op_a_sel_o      <= '0;
            op_b_sel_o      <= '0;
            mem_req_o       <= 1'b0;
            mem_we_o        <= 1'b0;
            mem_size_o      <= '0;
            gpr_we_o        <= 1'b0;
            wb_src_sel_o    <= 1'b0;
            branch_o        <= 1'b0;
            jal_o           <= 1'b0;
            jump_sel_o      <= '0;
            csr_op_o        <= '0;
            csr_o           <= 1'b0;
            illegal_instr_o <= 1'b0;
        end else if (load) begin
            out_valid_o     <= 1'b1;
            alu_op_o        <= alu_op_i;
            op_a_sel_o      <= op_a_sel_i;
            op_b_sel_o      <= op_b_sel_i;
            mem_req_o       <= mem_req_i;
            mem_we_o        <= mem_we_i;
            mem_size_o      <= mem_size_i;
            gpr_we_o        <= gpr_we_i;
            wb_src_sel_o    <= wb_src_sel_i;
            branch_o        <= branch_i;
            jal_o           <= jal_i;
            jump_sel_o      <= jump_sel_i;
            csr_op_o        <= csr_op_i;
            csr_o           <= csr_i;
            illegal_instr_o <= illegal_instr_i;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;                  // drained, fields kept
        end
    end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic      clk_i,
    input  logic      en_int_rst,
    input  logic      instr_valid_i,
    output logic      instr_ready_o,
    input  instr_t    instr_i,
    input  logic      irq_i,
    output logic      ctrl_valid_o,
    input  logic      ctrl_ready_i,
    output alu_op_t   alu_op_o,
    output op_a_sel_t op_a_sel_o,
    output op_b_sel_t op_b_sel_o,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output mem_size_t mem_size_o,
    output logic      gpr_we_o,
    output logic      wb_src_sel_o,
    output logic      branch_o,
    output logic      jal_o,
    output jump_sel_t jump_sel_o,
    output csr_op_t   csr_op_o,
    output logic      csr_o,
    output logic      illegal_instr_o
);

    alu_op_t   alu_op_r;
    alu_op_t   alu_op_i;
    alu_op_t   alu_op_br;
    mem_size_t load_size;
    mem_size_t store_size;
    logic      r_legal;
    logic      i_legal;
    logic      br_legal;
    logic      load_legal;
    logic      store_legal;

    // unregistered control word
    alu_op_t   dec_alu_op;
    op_a_sel_t dec_op_a_sel;
    op_b_sel_t dec_op_b_sel;
    logic      dec_mem_req;
    logic      dec_mem_we;
    mem_size_t dec_mem_size;
    logic      dec_gpr_we;
    logic      dec_wb_src_sel;
    logic      dec_branch;
    logic      dec_jal;
    jump_sel_t dec_jump_sel;
    csr_op_t   dec_csr_op;
    logic      dec_csr;
    logic      dec_illegal;

    funct_decoder u_funct_decoder (
        .instr_i       (instr_i),
        .alu_op_r_o    (alu_op_r),
        .alu_op_i_o    (alu_op_i),
        .alu_op_br_o   (alu_op_br),
        .load_size_o   (load_size),
        .store_size_o  (store_size),
        .r_legal_o     (r_legal),
        .i_legal_o     (i_legal),
        .br_legal_o    (br_legal),
        .load_legal_o  (load_legal),
        .store_legal_o (store_legal)
    );

    main_decoder u_main_decoder (
        .instr_i         (instr_i),
        .irq_i           (irq_i),
        .alu_op_r_i      (alu_op_r),
        .alu_op_i_i      (alu_op_i),
        .alu_op_br_i     (alu_op_br),
        .load_size_i     (load_size),
        .store_size_i    (store_size),
        .r_legal_i       (r_legal),
        .i_legal_i       (i_legal),
        .br_legal_i      (br_legal),
        .load_legal_i    (load_legal),
        .store_legal_i   (store_legal),
        .alu_op_o        (dec_alu_op),
        .op_a_sel_o      (dec_op_a_sel),
        .op_b_sel_o      (dec_op_b_sel),
        .mem_req_o       (dec_mem_req),
        .mem_we_o        (dec_mem_we),
        .mem_size_o      (dec_mem_size),
        .gpr_we_o        (dec_gpr_we),
        .wb_src_sel_o    (dec_wb_src_sel),
        .branch_o        (dec_branch),
        .jal_o           (dec_jal),
        .jump_sel_o      (dec_jump_sel),
        .csr_op_o        (dec_csr_op),
        .csr_o           (dec_csr),
        .illegal_instr_o (dec_illegal)
    );

    ctrl_output_reg u_ctrl_output_reg (
        .clk_i           (clk_i),
        .en_int_rst      (en_int_rst),
        .in_valid_i      (instr_valid_i),
        .in_ready_o      (instr_ready_o),
        .out_valid_o     (ctrl_valid_o),
        .out_ready_i     (ctrl_ready_i),
        .alu_op_i        (dec_alu_op),
        .op_a_sel_i      (dec_op_a_sel),
        .op_b_sel_i      (dec_op_b_sel),
        .mem_req_i       (dec_mem_req),
        .mem_we_i        (dec_mem_we),
        .mem_size_i      (dec_mem_size),
        .gpr_we_i        (dec_gpr_we),
        .wb_src_sel_i    (dec_wb_src_sel),
        .branch_i        (dec_branch),
        .jal_i           (dec_jal),
        .jump_sel_i      (dec_jump_sel),
        .csr_op_i        (dec_csr_op),
        .csr_i           (dec_csr),
        .illegal_instr_i (dec_illegal),
        .alu_op_o        (alu_op_o),
        .op_a_sel_o      (op_a_sel_o),
        .op_b_sel_o      (op_b_sel_o),
        .mem_req_o       (mem_req_o),
        .mem_we_o        (mem_we_o),
        .mem_size_o      (mem_size_o),
        .gpr_we_o        (gpr_we_o),
        .wb_src_sel_o    (wb_src_sel_o),
        .branch_o        (branch_o),
        .jal_o           (jal_o),
        .jump_sel_o      (jump_sel_o),
        .csr_op_o        (csr_op_o),
        .csr_o           (csr_o),
        .illegal_instr_o (illegal_instr_o)
    );

endmodule

// File: tests/decode_vectors.svh
// instr, irq, alu op, op a sel, op b sel, {mem_req, mem_we, mem_size},
// {gpr_we, wb_src_sel, branch, jal, illegal}, jump sel, {csr_op, csr}
add_row(32'h003100b3, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd0, 5'b00000, 5'b10000, 2'd0, 4'h0); // add
add_row(32'h403100b3, 1'b0, `DEC_ALU_SUB,  2'd0, 3'd0, 5'b00000, 5'b10000, 2'd0, 4'h0); // sub
add_row(32'h003110b3, 1'b0, `DEC_ALU_SLL,  2'd0, 3'd0, 5'b00000, 5'b10000, 2'd0, 4'h0); // sll
add_row(32'h003120b3, 1'b0, `DEC_ALU_SLTS, 2'd0, 3'd0, 5'b00000, 5'b10000, 2'd0, 4'h0); // slt
add_row(32'h003130b3, 1'b0, `DEC_ALU_SLTU, 2'd0, 3'd0, 5'b00000, 5'b10000, 2'd0, 4'h0); // sltu
add_row(32'h003140b3, 1'b0, `DEC_ALU_XOR,  2'd0, 3'd0, 5'b00000, 5'b10000, 2'd0, 4'h0); // xor
add_row(32'h003150b3, 1'b0, `DEC_ALU_SRL,  2'd0, 3'd0, 5'b00000, 5'b10000, 2'd0, 4'h0); // srl
add_row(32'h403150b3, 1'b0, `DEC_ALU_SRA,  2'd0, 3'd0, 5'b00000, 5'b10000, 2'd0, 4'h0); // sra
add_row(32'h003160b3, 1'b0, `DEC_ALU_OR,   2'd0, 3'd0, 5'b00000, 5'b10000, 2'd0, 4'h0); // or
add_row(32'h003170b3, 1'b0, `DEC_ALU_AND,  2'd0, 3'd0, 5'b00000, 5'b10000, 2'd0, 4'h0); // and
add_row(32'h00510093, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd1, 5'b00000, 5'b10000, 2'd0, 4'h0); // addi
add_row(32'h00511093, 1'b0, `DEC_ALU_SLL,  2'd0, 3'd1, 5'b00000, 5'b10000, 2'd0, 4'h0); // slli
add_row(32'h00512093, 1'b0, `DEC_ALU_SLTS, 2'd0, 3'd1, 5'b00000, 5'b10000, 2'd0, 4'h0); // slti
add_row(32'h00513093, 1'b0, `DEC_ALU_SLTU, 2'd0, 3'd1, 5'b00000, 5'b10000, 2'd0, 4'h0); // sltiu
add_row(32'h00514093, 1'b0, `DEC_ALU_XOR,  2'd0, 3'd1, 5'b00000, 5'b10000, 2'd0, 4'h0); // xori
add_row(32'h00515093, 1'b0, `DEC_ALU_SRL,  2'd0, 3'd1, 5'b00000, 5'b10000, 2'd0, 4'h0); // srli
add_row(32'h40515093, 1'b0, `DEC_ALU_SRA,  2'd0, 3'd1, 5'b00000, 5'b10000, 2'd0, 4'h0); // srai
add_row(32'h00516093, 1'b0, `DEC_ALU_OR,   2'd0, 3'd1, 5'b00000, 5'b10000, 2'd0, 4'h0); // ori
add_row(32'h00517093, 1'b0, `DEC_ALU_AND,  2'd0, 3'd1, 5'b00000, 5'b10000, 2'd0, 4'h0); // andi
add_row(32'h00410083, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd1, 5'b10000, 5'b11000, 2'd0, 4'h0); // lb
add_row(32'h00411083, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd1, 5'b10001, 5'b11000, 2'd0, 4'h0); // lh
add_row(32'h00412083, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd1, 5'b10010, 5'b11000, 2'd0, 4'h0); // lw
add_row(32'h00414083, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd1, 5'b10100, 5'b11000, 2'd0, 4'h0); // lbu
add_row(32'h00415083, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd1, 5'b10101, 5'b11000, 2'd0, 4'h0); // lhu
add_row(32'h00310423, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd3, 5'b11000, 5'b00000, 2'd0, 4'h0); // sb
add_row(32'h00311423, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd3, 5'b11001, 5'b00000, 2'd0, 4'h0); // sh
add_row(32'h00312423, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd3, 5'b11010, 5'b00000, 2'd0, 4'h0); // sw
add_row(32'h00310463, 1'b0, `DEC_ALU_EQ,   2'd0, 3'd0, 5'b00000, 5'b00100, 2'd0, 4'h0); // beq
add_row(32'h00311463, 1'b0, `DEC_ALU_NE,   2'd0, 3'd0, 5'b00000, 5'b00100, 2'd0, 4'h0); // bne
add_row(32'h00314463, 1'b0, `DEC_ALU_LTS,  2'd0, 3'd0, 5'b00000, 5'b00100, 2'd0, 4'h0); // blt
add_row(32'h00315463, 1'b0, `DEC_ALU_GES,  2'd0, 3'd0, 5'b00000, 5'b00100, 2'd0, 4'h0); // bge
add_row(32'h00316463, 1'b0, `DEC_ALU_LTU,  2'd0, 3'd0, 5'b00000, 5'b00100, 2'd0, 4'h0); // bltu
add_row(32'h00317463, 1'b0, `DEC_ALU_GEU,  2'd0, 3'd0, 5'b00000, 5'b00100, 2'd0, 4'h0); // bgeu
add_row(32'h123450b7, 1'b0, `DEC_ALU_ADD,  2'd2, 3'd2, 5'b00000, 5'b10000, 2'd0, 4'h0); // lui
add_row(32'h12345097, 1'b0, `DEC_ALU_ADD,  2'd1, 3'd2, 5'b00000, 5'b10000, 2'd0, 4'h0); // auipc
add_row(32'h010000ef, 1'b0, `DEC_ALU_ADD,  2'd1, 3'd4, 5'b00000, 5'b10010, 2'd0, 4'h0); // jal
add_row(32'h000100e7, 1'b0, `DEC_ALU_ADD,  2'd1, 3'd4, 5'b00000, 5'b10000, 2'd1, 4'h0); // jalr
add_row(32'h0ff0000f, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd0, 5'b00000, 5'b00000, 2'd0, 4'h0); // fence
add_row(32'h003100b0, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd0, 5'b00000, 5'b00001, 2'd0, 4'h0); // low bits
add_row(32'h0000000b, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd0, 5'b00000, 5'b00001, 2'd0, 4'h0); // custom-0
add_row(32'h023100b3, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd0, 5'b00000, 5'b00001, 2'd0, 4'h0); // funct7 1
add_row(32'h00312463, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd0, 5'b00000, 5'b00001, 2'd0, 4'h0); // branch 2
add_row(32'h00417083, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd0, 5'b00000, 5'b00001, 2'd0, 4'h0); // load 7
add_row(32'h00314423, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd0, 5'b00000, 5'b00001, 2'd0, 4'h0); // store 4
add_row(32'h000110e7, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd0, 5'b00000, 5'b00001, 2'd0, 4'h0); // jalr f3
add_row(32'h340150f3, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd0, 5'b00000, 5'b00001, 2'd0, 4'h0); // csrrwi
add_row(32'h003100b3, 1'b1, `DEC_ALU_ADD,  2'd1, 3'd4, 5'b00000, 5'b10000, 2'd3, 4'h8); // irq
add_row(32'h0000000b, 1'b1, `DEC_ALU_ADD,  2'd1, 3'd4, 5'b00000, 5'b10000, 2'd3, 4'h8); // irq
add_row(32'h30200073, 1'b0, `DEC_ALU_ADD,  2'd1, 3'd4, 5'b00000, 5'b10000, 2'd2, 4'h8); // mret
add_row(32'h340110f3, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd1, 5'b10001, 5'b11000, 2'd0, 4'h3); // csrrw
add_row(32'h340120f3, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd1, 5'b10010, 5'b11000, 2'd0, 4'h7); // csrrs
add_row(32'h340130f3, 1'b0, `DEC_ALU_ADD,  2'd0, 3'd1, 5'b10000, 5'b11000, 2'd0, 4'h5); // csrrc

// File: tests/tb_decode_stage.sv
`timescale 1ns/1ps

`include "decoder_settings.svh"

module tb_decode_stage import decode_pkg::*; ();

    localparam int timeout_cycles = 200;

    logic      clk_i;
    logic      en_int_rst;
    logic      instr_valid_i;
    logic      instr_ready_o;
    instr_t    instr_i;
    logic      irq_i;
    logic      ctrl_valid_o;
    logic      ctrl_ready_i;
    alu_op_t   alu_op_o;
    op_a_sel_t op_a_sel_o;
    op_b_sel_t op_b_sel_o;
    logic      mem_req_o;
    logic      mem_we_o;
    mem_size_t mem_size_o;
    logic      gpr_we_o;
    logic      wb_src_sel_o;
    logic      branch_o;
    logic      jal_o;
    jump_sel_t jump_sel_o;
    csr_op_t   csr_op_o;
    logic      csr_o;
    logic      illegal_instr_o;

    // expected table with one entry per row
    instr_t     vec_instr[$];
    logic       vec_irq[$];
    alu_op_t    vec_alu[$];
    op_a_sel_t  vec_op_a[$];
    op_b_sel_t  vec_op_b[$];
    logic [4:0] vec_mem[$];     // req, we, size
    logic [4:0] vec_flags[$];   // gpr_we, wb, branch, jal, illegal
    jump_sel_t  vec_jump[$];
    logic [3:0] vec_csr[$];     // csr op, csr flag

    integer      seed = 32'h95dd_2ccf;
    logic [31:0] rnd;
    int          accepted = 0;  // words taken by the DUT
    int          out_idx = 0;   // words seen leaving
    bit          ready_held = 0;

    decode_stage dut_i (.*);

    always #20 clk_i = ~clk_i;

    // random back-pressure unless held ready
    always @(posedge clk_i) begin
        rnd = $random(seed);
        ctrl_ready_i <= ready_held || rnd[0];
    end

    task automatic add_row(input instr_t instr, input logic irq, input alu_op_t alu,
                           input op_a_sel_t op_a, input op_b_sel_t op_b,
                           input logic [4:0] mem, input logic [4:0] flags,
                           input jump_sel_t jump, input logic [3:0] csr);
        vec_instr.push_back(instr);
        vec_irq.push_back(irq);
        vec_alu.push_back(alu);
        vec_op_a.push_back(op_a);
        vec_op_b.push_back(op_b);
        vec_mem.push_back(mem);
        vec_flags.push_back(flags);
        vec_jump.push_back(jump);
        vec_csr.push_back(csr);
    endtask

    task automatic fill_table();
        `include "decode_vectors.svh"
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic compare_word(input int row);
        check_value("alu_op_o", alu_op_o, vec_alu[row]);
        check_value("op_a_sel_o", op_a_sel_o, vec_op_a[row]);
        check_value("op_b_sel_o", op_b_sel_o, vec_op_b[row]);
        check_value("mem_req_o", mem_req_o, vec_mem[row][4]);
        check_value("mem_we_o", mem_we_o, vec_mem[row][3]);
        check_value("mem_size_o", mem_size_o, vec_mem[row][2:0]);
        check_value("gpr_we_o", gpr_we_o, vec_flags[row][4]);
        check_value("wb_src_sel_o", wb_src_sel_o, vec_flags[row][3]);
        check_value("branch_o", branch_o, vec_flags[row][2]);
        check_value("jal_o", jal_o, vec_flags[row][1]);
        check_value("illegal_instr_o", illegal_instr_o, vec_flags[row][0]);
        check_value("jump_sel_o", jump_sel_o, vec_jump[row]);
        check_value("csr_op_o", csr_op_o, vec_csr[row][3:1]);
        check_value("csr_o", csr_o, vec_csr[row][0]);
    endtask

    // a held word is compared again every cycle
    always @(negedge clk_i) begin
        check_value("ctrl_valid_o", ctrl_valid_o, accepted > out_idx);
        check_value("instr_ready_o", instr_ready_o, accepted == out_idx || ctrl_ready_i);
        if (ctrl_valid_o) begin
            compare_word(out_idx % vec_instr.size());
            if (ctrl_ready_i)
                out_idx++;                          // leaves at next edge
        end
    end

    task automatic wait_accept();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!instr_ready_o && cycles < timeout_cycles) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!instr_ready_o)
            report_timeout("instr_ready_o");
        @(posedge clk_i);
        accepted++;
    endtask

    task automatic apply_table();
        int i;
        for (i = 0; i < vec_instr.size(); i++) begin
            instr_valid_i <= 1'b1;
            instr_i       <= vec_instr[i];
            irq_i         <= vec_irq[i];
            wait_accept();
        end
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        irq_i         <= 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (out_idx != accepted && cycles < timeout_cycles) begin
            @(posedge clk_i);
            cycles++;
        end
        if (out_idx != accepted)
            report_timeout("the output register to drain");
    endtask

    initial begin
        clk_i         = 1'b0;
        en_int_rst    = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        irq_i         = 1'b0;
        ctrl_ready_i  = 1'b0;
        fill_table();
        repeat (2) @(posedge clk_i);
        en_int_rst <= 1'b0;
        @(negedge clk_i);
        check_value("ctrl_valid_o", ctrl_valid_o, 1'b0);
        check_value("control outputs", {alu_op_o, op_a_sel_o, op_b_sel_o, mem_req_o,
                    mem_we_o, mem_size_o, gpr_we_o, wb_src_sel_o, branch_o, jal_o,
                    jump_sel_o, csr_op_o, csr_o, illegal_instr_o}, 32'h0);
        @(posedge clk_i);
        apply_table();                              // random back-pressure
        wait_drain();
        @(negedge clk_i);
        ready_held = 1'b1;
        @(posedge clk_i);
        apply_table();                              // one word per cycle
        wait_drain();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
+incdir+tests
src/decode_pkg.sv
src/funct_decoder.sv
src/main_decoder.sv
src/ctrl_output_reg.sv
src/decode_stage.sv
tests/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module tb_decode_stage -f list.f \
    && ./obj_dir/Vtb_decode_stage \
    || exit 1
